// ==== alu_core.f ====
alu_pkg.sv
alu_flag_if.sv
alu_arith.sv
alu_logic.sv
alu_shift_seq.sv
alu_flag_reg.sv
alu_core.sv
alu_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := alu_core_tb
RTL_TOP   := alu_core
FILELIST  := alu_core.f
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== alu_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_core_tb;

    localparam int max_wait = 40;   // cycles

    logic             clk;
    logic             rst;
    logic             go;
    alu_pkg::alu_op_t op;
    alu_pkg::width_t  w;
    alu_pkg::data_t   op0;
    alu_pkg::data_t   op1;
    alu_pkg::data_t   dout;
    logic [7:0]       flags;
    logic             busy;
    alu_pkg::width_t  we;

    logic [31:0]      seed;
    alu_pkg::flags_t  mf;          // model of the flag register
    alu_pkg::data_t   exp_dout;
    logic [7:0]       exp_flags;
    alu_pkg::width_t  exp_we;

    alu_core uut (
        .clk   (clk),
        .rst   (rst),
        .go    (go),
        .op    (op),
        .w     (w),
        .op0   (op0),
        .op1   (op1),
        .dout  (dout),
        .flags (flags),
        .busy  (busy),
        .we    (we)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int width_bits(alu_pkg::width_t wd);
        return wd[0] ? 8 : wd[1] ? 16 : 32;
    endfunction

    function automatic logic [7:0] flag_image(alu_pkg::flags_t f);
        logic [7:0] img;
        img    = '0;
        img[7] = f.s;
        img[6] = f.z;
        img[4] = f.h;
        img[2] = f.v;
        img[1] = f.n;
        img[0] = f.c;
        return img;
    endfunction

    // sign, zero and parity of a result at its width
    task automatic set_szv(alu_pkg::data_t r, alu_pkg::width_t wd);
        int nb;
        nb   = width_bits(wd);
        mf.s = r[nb-1];
        mf.z = (r << (32 - nb)) == '0;
        mf.v = wd[0] ? ~^r[7:0] : ~^r[15:0];
    endtask

    task automatic model_single(input alu_pkg::alu_op_t o, input alu_pkg::width_t wd,
                                input alu_pkg::data_t a, input alu_pkg::data_t b,
                                output logic writes);
        int             nb;
        logic           sub;
        logic           cin;
        alu_pkg::data_t am;
        alu_pkg::data_t bm;
        alu_pkg::data_t r;
        longint         half;
        longint         sa;
        longint         sb;
        longint         exact;
        nb     = width_bits(wd);
        sub    = o inside {alu_pkg::alu_sub, alu_pkg::alu_sbc, alu_pkg::alu_cp};
        cin    = o inside {alu_pkg::alu_adc, alu_pkg::alu_sbc} && mf.c;
        writes = o inside {alu_pkg::alu_add, alu_pkg::alu_adc, alu_pkg::alu_sub,
                           alu_pkg::alu_sbc, alu_pkg::alu_and, alu_pkg::alu_or, alu_pkg::alu_xor};
        am     = a << (32 - nb) >> (32 - nb);
        bm     = b << (32 - nb) >> (32 - nb);
        half   = longint'(1) << (nb - 1);
        sa     = longint'(am) - (am[nb-1] ? 2 * half : longint'(0));
        sb     = longint'(bm) - (bm[nb-1] ? 2 * half : longint'(0));
        case (o)
            alu_pkg::alu_and:                  r = a & b;
            alu_pkg::alu_or:                   r = a | b;
            alu_pkg::alu_xor:                  r = a ^ b;
            alu_pkg::alu_add, alu_pkg::alu_adc: r = a + b + 32'(cin);
            default:                           r = a - b - 32'(cin);
        endcase
        if (o inside {alu_pkg::alu_add, alu_pkg::alu_adc} || sub) begin
            set_szv(r, wd);
            if (sub) begin
                mf.h  = int'(a[3:0]) < int'(b[3:0]) + int'(cin);   // borrow from bit 4
                mf.c  = longint'(am) < longint'(bm) + longint'(cin);
                exact = sa - sb - longint'(cin);
            end else begin
                mf.h  = int'(a[3:0]) + int'(b[3:0]) + int'(cin) > 15;
                mf.c  = longint'(am) + longint'(bm) + longint'(cin) >= 2 * half;
                exact = sa + sb + longint'(cin);
            end
            mf.v = exact >= half || exact < -half;
            mf.n = sub;
        end else if (writes) begin
            set_szv(r, wd);
            mf.h = o == alu_pkg::alu_and;
            mf.n = 1'b0;
            mf.c = 1'b0;
        end else begin
            case (o)
                alu_pkg::alu_scf: mf.c = 1'b1;
                alu_pkg::alu_rcf: mf.c = 1'b0;
                alu_pkg::alu_ccf: mf.c = ~mf.c;
                default:          mf.c = ~mf.z;
            endcase
            if (o inside {alu_pkg::alu_scf, alu_pkg::alu_rcf})
                mf.h = 1'b0;
            mf.n = 1'b0;
        end
        if (writes) begin
            exp_dout = r;
            exp_we   = wd;
        end
        exp_flags = flag_image(mf);
    endtask

    // one bit position per step, bits above the width untouched
    task automatic model_shift(alu_pkg::alu_op_t o, alu_pkg::width_t wd,
                               alu_pkg::data_t a, int k);
        int             nb;
        int             i;
        int             j;
        logic           left;
        logic           fill;
        logic           msb;
        logic           lsb;
        alu_pkg::data_t r;
        nb   = width_bits(wd);
        left = o inside {alu_pkg::alu_rl, alu_pkg::alu_rlc, alu_pkg::alu_sla, alu_pkg::alu_sll};
        r    = a;
        for (i = 0; i < k; i++) begin
            msb = r[nb-1];
            lsb = r[0];
            case (o)
                alu_pkg::alu_rl, alu_pkg::alu_rr:   fill = mf.c;
                alu_pkg::alu_rlc, alu_pkg::alu_sra: fill = msb;
                alu_pkg::alu_rrc:                   fill = lsb;
                default:                            fill = 1'b0;
            endcase
            if (left) begin
                for (j = nb - 1; j > 0; j--)
                    r[j] = r[j-1];
                r[0] = fill;
                mf.c = msb;
            end else begin
                for (j = 0; j < nb - 1; j++)
                    r[j] = r[j+1];
                r[nb-1] = fill;
                mf.c    = lsb;
            end
        end
        set_szv(r, wd);
        mf.h      = 1'b0;
        mf.n      = 1'b0;
        exp_dout  = r;
        exp_we    = wd;
        exp_flags = flag_image(mf);
    endtask

    // falling edges from go until the write pulse shows
    task automatic wait_for_we(input logic shifting, input logic intrude, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            go = intrude && cycles == 1;
            if (go) begin
                op  = alu_pkg::alu_add;   // must be ignored while busy
                op0 = next_rand();
                op1 = next_rand();
            end
            if (cycles > max_wait) begin
                $display("result never arrived: no write pulse within %0d cycles", max_wait);
                abort_run();
            end
            if (shifting && we == '0)
                assert (busy) else value_error("busy low before the shift finished");
        end while (we == '0);
    endtask

    task automatic run_single(alu_pkg::alu_op_t o, alu_pkg::width_t wd,
                              alu_pkg::data_t a, alu_pkg::data_t b);
        alu_pkg::data_t held;
        logic           writes;
        int             cycles;
        held = dout;
        op   = o;
        w    = wd;
        op0  = a;
        op1  = b;
        go   = 1'b1;
        model_single(o, wd, a, b, writes);
        if (writes) begin
            wait_for_we(1'b0, 1'b0, cycles);
            assert (cycles == 1)
                else value_error($sformatf("%s: write pulse %0d cycles late",
                                           o.name(), cycles - 1));
        end else begin
            @(negedge clk);
            go = 1'b0;
            assert (we == '0 && dout == held && flags == exp_flags)
                else value_error($sformatf("%s: flags %h we %b dout %h, expected flags %h",
                                           o.name(), flags, we, dout, exp_flags));
        end
        @(negedge clk);
    endtask

    task automatic run_shift(alu_pkg::alu_op_t o, alu_pkg::width_t wd,
                             alu_pkg::data_t a, alu_pkg::data_t b, logic intrude);
        int k;
        int cycles;
        k   = b[3:0] == 4'd0 ? 16 : int'(b[3:0]);
        op  = o;
        w   = wd;
        op0 = a;
        op1 = b;
        go  = 1'b1;
        model_shift(o, wd, a, k);
        wait_for_we(1'b1, intrude, cycles);
        assert (cycles == k + 1)
            else value_error($sformatf("%s: write pulse %0d cycles after go, expected %0d",
                                       o.name(), cycles - 1, k));
        assert (!busy)
            else value_error($sformatf("%s: busy still high at the write pulse", o.name()));
        repeat (3) begin
            @(negedge clk);
            assert (we == '0 && !busy) else value_error("extra write pulse after the shift");
        end
    endtask

    a_result: assert property (@(posedge clk) disable iff (rst)
        we != '0 |-> dout == exp_dout && flags == exp_flags && we == exp_we)
        else value_error($sformatf("dout %h flags %h we %b, expected %h %h %b",
                                   $sampled(dout), $sampled(flags), $sampled(we),
                                   exp_dout, exp_flags, exp_we));

    a_flags_hold: assert property (@(posedge clk) disable iff (rst)
        busy |-> $stable(flags))
        else value_error("flags changed before the final shift step");

    initial begin
        alu_pkg::width_t  widths [3];
        alu_pkg::alu_op_t arith_ops [5];
        alu_pkg::alu_op_t shift_ops [8];
        widths    = '{3'b001, 3'b010, 3'b100};
        arith_ops = '{alu_pkg::alu_add, alu_pkg::alu_adc, alu_pkg::alu_sub,
                      alu_pkg::alu_sbc, alu_pkg::alu_cp};
        shift_ops = '{alu_pkg::alu_rl, alu_pkg::alu_rr, alu_pkg::alu_rlc, alu_pkg::alu_rrc,
                      alu_pkg::alu_sla, alu_pkg::alu_sra, alu_pkg::alu_sll, alu_pkg::alu_srl};
        seed      = 32'd13;
        rst       = 1'b1;
        go        = 1'b0;
        op        = alu_pkg::alu_add;
        w         = 3'b001;
        op0       = '0;
        op1       = '0;
        mf        = '0;
        exp_dout  = '0;
        exp_flags = '0;
        exp_we    = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (dout == '0 && flags == 8'd0 && !busy && we == '0)
            else value_error("outputs not cleared by reset");

        foreach (widths[i]) begin
            foreach (arith_ops[j])
                repeat (6) run_single(arith_ops[j], widths[i], next_rand(), next_rand());
            repeat (4) begin
                run_single(alu_pkg::alu_and, widths[i], next_rand(), next_rand());
                run_single(alu_pkg::alu_or, widths[i], next_rand(), next_rand());
                run_single(alu_pkg::alu_xor, widths[i], next_rand(), next_rand());
            end
            run_single(alu_pkg::alu_scf, widths[i], next_rand(), next_rand());
            run_single(alu_pkg::alu_ccf, widths[i], next_rand(), next_rand());
            run_single(alu_pkg::alu_ccf, widths[i], next_rand(), next_rand());
            run_single(alu_pkg::alu_xor, widths[i], 32'h1234_5678, 32'h1234_5678);  // zero
            run_single(alu_pkg::alu_scf, widths[i], next_rand(), next_rand());
            run_single(alu_pkg::alu_zcf, widths[i], next_rand(), next_rand());
            run_single(alu_pkg::alu_and, widths[i], 32'h0000_0181, 32'h0000_0181);  // nonzero
            run_single(alu_pkg::alu_zcf, widths[i], next_rand(), next_rand());
            run_single(alu_pkg::alu_rcf, widths[i], next_rand(), next_rand());
        end
        run_single(alu_pkg::alu_add, 3'b001, 32'h0000_007f, 32'h0000_0001);  // byte overflow
        run_single(alu_pkg::alu_sub, 3'b010, 32'h0000_8000, 32'h0000_0001);
        run_single(alu_pkg::alu_scf, 3'b100, 32'd0, 32'd0);
        run_single(alu_pkg::alu_adc, 3'b100, 32'hffff_ffff, 32'd0);

        foreach (shift_ops[j])
            foreach (widths[i])
                repeat (2) run_shift(shift_ops[j], widths[i], next_rand(), next_rand(), 1'b0);
        run_shift(alu_pkg::alu_rl, 3'b010, next_rand(), 32'h0000_0010, 1'b0);   // 16 steps
        run_shift(alu_pkg::alu_sra, 3'b100, 32'h8000_0001, 32'h0000_0005, 1'b1);
        run_shift(alu_pkg::alu_rrc, 3'b001, next_rand(), 32'h0000_0001, 1'b1);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== alu_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_core (
    input  logic             clk,
    input  logic             rst,
    input  logic             go,
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::width_t  w,
    input  alu_pkg::data_t   op0,
    input  alu_pkg::data_t   op1,
    output alu_pkg::data_t   dout,
    output logic [7:0]       flags,
    output logic             busy,
    output alu_pkg::width_t  we
);

    alu_pkg::data_t  arith_rslt;
    alu_pkg::data_t  logic_rslt;
    alu_pkg::data_t  shift_rslt;
    alu_pkg::flags_t fl;
    logic            shift_busy;
    logic            shift_last;

    alu_flag_if arith_f ();
    alu_flag_if logic_f ();
    alu_flag_if shift_f ();

    alu_arith u_arith (
        .op   (op),
        .w    (w),
        .op0  (op0),
        .op1  (op1),
        .f    (arith_f),
        .rslt (arith_rslt)
    );

    alu_logic u_logic (
        .op   (op),
        .w    (w),
        .op0  (op0),
        .op1  (op1),
        .f    (logic_f),
        .rslt (logic_rslt)
    );

    alu_shift_seq u_shift (
        .clk  (clk),
        .rst  (rst),
        .go   (go),
        .op   (op),
        .w    (w),
        .op0  (op0),
        .op1  (op1),      // low nibble is the count
        .f    (shift_f),
        .rslt (shift_rslt),
        .busy (shift_busy),
        .last (shift_last)
    );

    alu_flag_reg u_flag_reg (
        .clk        (clk),
        .rst        (rst),
        .go         (go),
        .op         (op),
        .w          (w),
        .arith_f    (arith_f),
        .logic_f    (logic_f),
        .shift_f    (shift_f),
        .arith_rslt (arith_rslt),
        .logic_rslt (logic_rslt),
        .shift_rslt (shift_rslt),
        .shift_busy (shift_busy),
        .shift_last (shift_last),
        .dout       (dout),
        .fl         (fl),
        .busy       (busy),
        .we         (we)
    );

    assign flags = alu_pkg::flag_byte(fl);   // s z - h - v n c

endmodule

`default_nettype wire

// ==== alu_flag_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_flag_reg (
    input  logic             clk,
    input  logic             rst,
    input  logic             go,
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::width_t  w,
    alu_flag_if.regs         arith_f,
    alu_flag_if.regs         logic_f,
    alu_flag_if.regs         shift_f,
    input  alu_pkg::data_t   arith_rslt,
    input  alu_pkg::data_t   logic_rslt,
    input  alu_pkg::data_t   shift_rslt,
    input  logic             shift_busy,
    input  logic             shift_last,
    output alu_pkg::data_t   dout,
    output alu_pkg::flags_t  fl,
    output logic             busy,
    output alu_pkg::width_t  we
);

    logic            accept;
    alu_pkg::flags_t sel_nx;
    logic            sel_upd;
    alu_pkg::data_t  sel_rslt;
    alu_pkg::width_t w_hold;   // width of the running shift

    assign accept = go && !shift_busy;
    assign busy   = shift_busy;

    always_comb begin
        sel_nx   = arith_f.nx;
        sel_upd  = 1'b0;
        sel_rslt = arith_rslt;
        if (alu_pkg::op_is_arith(op)) begin
            sel_upd = arith_f.upd;
        end else if (alu_pkg::op_is_logic(op)) begin
            sel_nx   = logic_f.nx;
            sel_upd  = logic_f.upd;
            sel_rslt = logic_rslt;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout   <= '0;
            fl     <= '0;
            we     <= '0;
            w_hold <= '0;
        end else begin
            we <= '0;
            if (shift_last) begin
                dout <= shift_rslt;
                we   <= w_hold;
                if (shift_f.upd)
                    fl <= shift_f.nx;
            end else if (accept) begin
                w_hold <= w;
                if (sel_upd)
                    fl <= sel_nx;
                if (alu_pkg::op_single_write(op)) begin
                    dout <= sel_rslt;
                    we   <= w;
                end
            end
        end
    end

    assign arith_f.cur = fl;
    assign logic_f.cur = fl;
    assign shift_f.cur = fl;

    a_no_we_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> we == '0)
        else $error("alu_flag_reg: write pulse while a shift is running");

endmodule

`default_nettype wire

// ==== alu_shift_seq.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_shift_seq (
    input  logic             clk,
    input  logic             rst,
    input  logic             go,
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::width_t  w,
    input  alu_pkg::data_t   op0,
    input  alu_pkg::data_t   op1,
    alu_flag_if.unit         f,
    output alu_pkg::data_t   rslt,
    output logic             busy,
    output logic             last
);

    localparam logic [alu_pkg::shift_cnt_w-1:0] cnt_one = 1;

    alu_pkg::alu_op_t                op_q;
    alu_pkg::width_t                 w_q;
    alu_pkg::data_t                  work;
    logic                            carry_run;  // carry as it would be after each step
    logic [alu_pkg::shift_cnt_w-1:0] cnt;
    logic                            load;
    logic                            left;
    logic                            fill;
    logic                            out_bit;
    alu_pkg::flags_t                 nx;

    assign load = go && !busy && alu_pkg::op_is_shift(op);
    assign last = busy && cnt == cnt_one;

    always_comb begin
        left = op_q inside {alu_pkg::alu_rl, alu_pkg::alu_rlc, alu_pkg::alu_sla, alu_pkg::alu_sll};
        case (op_q)
            alu_pkg::alu_rl, alu_pkg::alu_rr: fill = carry_run;
            alu_pkg::alu_rlc:                 fill = alu_pkg::msb_of(work, w_q);
            alu_pkg::alu_rrc:                 fill = work[0];
            alu_pkg::alu_sra:                 fill = alu_pkg::msb_of(work, w_q); // sign fill
            default:                          fill = 1'b0;
        endcase

        rslt = work;   // bits above the width stay as loaded
        if (left) begin
            out_bit = alu_pkg::msb_of(work, w_q);
            if (w_q[0])
                rslt[7:0] = {work[6:0], fill};
            else if (w_q[1])
                rslt[15:0] = {work[14:0], fill};
            else
                rslt = {work[30:0], fill};
        end else begin
            out_bit = work[0];
            if (w_q[0])
                rslt[7:0] = {fill, work[7:1]};
            else if (w_q[1])
                rslt[15:0] = {fill, work[15:1]};
            else
                rslt = {fill, work[31:1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (load) begin
            busy <= 1'b1;
            cnt  <= {op1[3:0] == 4'd0, op1[3:0]};   // 0 runs 16 steps
        end else if (busy) begin
            busy <= !last;
            cnt  <= cnt - cnt_one;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            work      <= op0;
            op_q      <= op;
            w_q       <= w;
            carry_run <= f.cur.c;
        end else if (busy) begin
            work      <= rslt;
            carry_run <= out_bit;
        end
    end

    always_comb begin
        nx.s = alu_pkg::msb_of(rslt, w_q);
        nx.z = alu_pkg::is_zero_at(rslt, w_q);
        nx.h = 1'b0;
        nx.v = alu_pkg::even_parity(rslt, w_q);
        nx.n = 1'b0;
        nx.c = out_bit;
    end

    assign f.nx  = nx;
    assign f.upd = last;   // flags only from the final step

    a_cnt_no_underflow: assert property (@(posedge clk) disable iff (rst)
        busy |-> cnt != '0)
        else $error("alu_shift_seq: step counter ran out while busy");

endmodule

`default_nettype wire

// ==== alu_logic.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_logic (
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::width_t  w,
    input  alu_pkg::data_t   op0,
    input  alu_pkg::data_t   op1,
    alu_flag_if.unit         f,
    output alu_pkg::data_t   rslt
);

    logic            bitwise;
    alu_pkg::flags_t nx;

    always_comb begin
        case (op)
            alu_pkg::alu_and: rslt = op0 & op1;
            alu_pkg::alu_or:  rslt = op0 | op1;
            alu_pkg::alu_xor: rslt = op0 ^ op1;
            default:          rslt = '0;   // carry ops have no result
        endcase
    end

    assign bitwise = op inside {alu_pkg::alu_and, alu_pkg::alu_or, alu_pkg::alu_xor};

    always_comb begin
        nx = f.cur;    // untouched flags keep their value
        if (bitwise) begin
            nx.s = alu_pkg::msb_of(rslt, w);
            nx.z = alu_pkg::is_zero_at(rslt, w);
            nx.h = op == alu_pkg::alu_and;
            nx.v = alu_pkg::even_parity(rslt, w);
            nx.n = 1'b0;
            nx.c = 1'b0;
        end
        case (op)
            alu_pkg::alu_scf: begin
                nx.c = 1'b1;
                nx.n = 1'b0;
                nx.h = 1'b0;
            end
            alu_pkg::alu_rcf: begin
                nx.c = 1'b0;
                nx.n = 1'b0;
                nx.h = 1'b0;
            end
            alu_pkg::alu_ccf: begin
                nx.c = ~f.cur.c;
                nx.n = 1'b0;
            end
            alu_pkg::alu_zcf: begin
                nx.c = ~f.cur.z;
                nx.n = 1'b0;
            end
            default: ;
        endcase
    end

    assign f.nx  = nx;
    assign f.upd = alu_pkg::op_is_logic(op);

endmodule

`default_nettype wire

// ==== alu_arith.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_arith (
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::width_t  w,
    input  alu_pkg::data_t   op0,
    input  alu_pkg::data_t   op1,
    alu_flag_if.unit         f,
    output alu_pkg::data_t   rslt
);

    logic            sub;
    logic            cin;
    logic            ci;       // carry into bit 0 of the adder
    alu_pkg::data_t  b;
    logic [3:0]      cc;       // nibble, byte, word, long carries
    logic [32:0]     ext_sum;
    logic            c_at_w;
    alu_pkg::flags_t nx;

    function automatic logic [32:0] sext(alu_pkg::data_t x, alu_pkg::width_t wd);
        if (wd[0]) return {{25{x[7]}}, x[7:0]};
        if (wd[1]) return {{17{x[15]}}, x[15:0]};
        return {x[31], x};
    endfunction

    always_comb begin
        sub = op inside {alu_pkg::alu_sub, alu_pkg::alu_sbc, alu_pkg::alu_cp};
        cin = (op == alu_pkg::alu_adc || op == alu_pkg::alu_sbc) && f.cur.c;
        b   = sub ? ~op1 : op1;    // subtract as a + ~b + 1
        ci  = cin ^ sub;

        {cc[0], rslt[3:0]}   = {1'b0, op0[3:0]}   + {1'b0, b[3:0]}   + {4'd0, ci};
        {cc[1], rslt[7:4]}   = {1'b0, op0[7:4]}   + {1'b0, b[7:4]}   + {4'd0, cc[0]};
        {cc[2], rslt[15:8]}  = {1'b0, op0[15:8]}  + {1'b0, b[15:8]}  + {8'd0, cc[1]};
        {cc[3], rslt[31:16]} = {1'b0, op0[31:16]} + {1'b0, b[31:16]} + {16'd0, cc[2]};

        ext_sum = sext(op0, w) + sext(b, w) + {32'd0, ci};
        c_at_w  = w[0] ? cc[1] : w[1] ? cc[2] : cc[3];
    end

    always_comb begin
        nx.s = alu_pkg::msb_of(rslt, w);
        nx.z = alu_pkg::is_zero_at(rslt, w);
        nx.h = cc[0] ^ sub;        // borrow on subtract
        nx.v = ext_sum[32] ^ alu_pkg::msb_of(rslt, w);
        nx.n = sub;
        nx.c = c_at_w ^ sub;
    end

    assign f.nx  = nx;
    assign f.upd = alu_pkg::op_is_arith(op);

    // the CPU decoder must never hand over two widths at once
    always_comb begin
        assert ($isunknown(w) || $onehot0(w))
            else $error("alu_arith: width code %b is not one-hot", w);
    end

endmodule

`default_nettype wire

// ==== alu_flag_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface alu_flag_if;

    alu_pkg::flags_t nx;    // flags proposed by the unit
    logic            upd;   // unit wants the flags written
    alu_pkg::flags_t cur;   // registered flags

    modport unit (
        output nx,
        output upd,
        input  cur
    );

    modport regs (
        input  nx,
        input  upd,
        output cur
    );

endinterface

`default_nettype wire

// ==== alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    localparam int data_w      = 32;
    localparam int shift_cnt_w = 5;    // counts up to 16

    typedef logic [data_w-1:0] data_t;
    typedef logic [2:0]        width_t; // one-hot, bit 0 byte, bit 1 word, bit 2 long

    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_adc = 5'd1,
        alu_sub = 5'd2,
        alu_sbc = 5'd3,
        alu_cp  = 5'd4,
        alu_and = 5'd5,
        alu_or  = 5'd6,
        alu_xor = 5'd7,
        alu_scf = 5'd8,
        alu_rcf = 5'd9,
        alu_ccf = 5'd10,
        alu_zcf = 5'd11,
        alu_rl  = 5'd12,
        alu_rr  = 5'd13,
        alu_rlc = 5'd14,
        alu_rrc = 5'd15,
        alu_sla = 5'd16,
        alu_sra = 5'd17,
        alu_sll = 5'd18,
        alu_srl = 5'd19
    } alu_op_t;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic v;   // overflow or parity
        logic n;
        logic c;
    } flags_t;

    function automatic logic [7:0] flag_byte(flags_t f);
        return {f.s, f.z, 1'b0, f.h, 1'b0, f.v, f.n, f.c};
    endfunction

    function automatic logic msb_of(data_t x, width_t w);
        if (w[0]) return x[7];
        if (w[1]) return x[15];
        return x[31];
    endfunction

    function automatic logic is_zero_at(data_t x, width_t w);
        if (w[0]) return x[7:0] == 8'd0;
        if (w[1]) return x[15:0] == 16'd0;
        return x == '0;
    endfunction

    function automatic logic even_parity(data_t x, width_t w);
        if (w[0]) return ~^x[7:0];
        return ~^x[15:0];   // word and long look at the low half only
    endfunction

    function automatic logic op_is_arith(alu_op_t op);
        return op inside {alu_add, alu_adc, alu_sub, alu_sbc, alu_cp};
    endfunction

    function automatic logic op_is_logic(alu_op_t op);
        return op inside {alu_and, alu_or, alu_xor, alu_scf, alu_rcf, alu_ccf, alu_zcf};
    endfunction

    function automatic logic op_is_shift(alu_op_t op);
        return op inside {alu_rl, alu_rr, alu_rlc, alu_rrc, alu_sla, alu_sra, alu_sll, alu_srl};
    endfunction

    // result written on the go edge itself
    function automatic logic op_single_write(alu_op_t op);
        return op inside {alu_add, alu_adc, alu_sub, alu_sbc, alu_and, alu_or, alu_xor};
    endfunction

endpackage

`default_nettype wire
